//--- flist.f
source/i2c_eeprom_pkg.sv
source/i2c_rate_gen.sv
source/i2c_bus_engine.sv
source/i2c_xfer_seq.sv
source/i2c_eeprom_ctrl.sv
tb/eeprom_slave_model.sv
tb/tb_i2c_eeprom_ctrl.sv

//--- run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module tb_i2c_eeprom_ctrl
./obj_dir/Vtb_i2c_eeprom_ctrl | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "FAIL"
	exit 1
fi
echo "PASS"

//--- source/i2c_bus_engine.sv
`timescale 1ns/10ps
module i2c_bus_engine import i2c_eeprom_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_tick,
	input  logic      i_cmd_valid,
	input  byte_cmd_t i_cmd,
	input  logic      i_sda,
	output logic      o_busy,
	output logic      o_byte_done,
	output logic      o_ack_ok,
	output byte_t     o_rx_byte,
	output logic      o_scl_oe,
	output logic      o_sda_oe
);

	engine_op_t op;
	logic [1:0] phase;
	logic [2:0] bit_cnt;
	byte_cmd_t cmd_q;
	byte_t shreg;

	assign o_busy = (op != OP_IDLE);
	// shift register doubles as receive buffer
	assign o_rx_byte = shreg;

	// four ticks per scl period
	// phase 0 pulls scl low, 1 moves sda, 2 releases scl and samples
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			op <= OP_IDLE;
			phase <= 2'd0;
			bit_cnt <= 3'd0;
			o_byte_done <= 1'b0;
			o_ack_ok <= 1'b0;
			o_scl_oe <= 1'b0;
			o_sda_oe <= 1'b0;
		end else begin
			o_byte_done <= 1'b0;
			if (op == OP_IDLE) begin
				phase <= 2'd0;
				bit_cnt <= 3'd0;
				// lines hold their level between bytes
				if (i_cmd_valid) begin
					if (i_cmd.start && i_cmd.rx) begin
						op <= OP_STOP;
					end else if (i_cmd.start) begin
						op <= OP_START;
					end else begin
						op <= OP_BIT;
					end
				end
			end else if (i_tick) begin
				phase <= phase + 2'd1;
				case (op)
					OP_START: begin
						// sda falls with scl high
						if (phase == 2'd2) begin
							o_sda_oe <= 1'b1;
						end
						if (phase == 2'd3) begin
							op <= OP_BIT;
						end
					end
					OP_BIT: begin
						case (phase)
							2'd0: o_scl_oe <= 1'b1;
							// msb first and released when receiving
							2'd1: o_sda_oe <= ~cmd_q.rx & ~shreg[7];
							2'd2: o_scl_oe <= 1'b0;
							default: begin
								bit_cnt <= bit_cnt + 3'd1;
								if (bit_cnt == 3'd7) begin
									op <= OP_ACK;
								end
							end
						endcase
					end
					OP_ACK: begin
						case (phase)
							2'd0: o_scl_oe <= 1'b1;
							// slave acks a sent byte and master acks a received one
							2'd1: o_sda_oe <= cmd_q.rx & cmd_q.m_ack;
							2'd2: begin
								o_scl_oe <= 1'b0;
								o_ack_ok <= ~i_sda;
							end
							default: begin
								if (cmd_q.stop) begin
									op <= OP_STOP;
								end else begin
									op <= OP_IDLE;
									o_byte_done <= 1'b1;
								end
							end
						endcase
					end
					OP_STOP: begin
						case (phase)
							2'd0: o_scl_oe <= 1'b1;
							2'd1: o_sda_oe <= 1'b1;
							2'd2: o_scl_oe <= 1'b0;
							default: begin
								// sda rises with scl high
								o_sda_oe <= 1'b0;
								op <= OP_IDLE;
								o_byte_done <= 1'b1;
							end
						endcase
					end
					default: op <= OP_IDLE;
				endcase
			end
		end
	end

	// command and shift data
	// sent bits come back in through i_sda too
	always_ff @(posedge i_clk) begin
		if (op == OP_IDLE && i_cmd_valid) begin
			cmd_q <= i_cmd;
			shreg <= i_cmd.tx_byte;
		end else if (i_tick && op == OP_BIT && phase == 2'd2) begin
			shreg <= {shreg[6:0], i_sda};
		end
	end

	// sda only moves under a high scl for start and stop
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(!o_scl_oe && !$past(o_scl_oe) && $past(op) != OP_START && $past(op) != OP_STOP)
		|-> $stable(o_sda_oe));

	// a byte closes out of a busy engine and leaves scl released
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_byte_done |-> (!o_scl_oe && $past(o_busy)));

endmodule

//--- source/i2c_eeprom_ctrl.sv
`timescale 1ns/10ps
module i2c_eeprom_ctrl import i2c_eeprom_pkg::*; #(
	parameter rate_t P_RATE_DEFAULT = RATE_DEFAULT
) (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_start,
	input  xfer_req_t i_req,
	input  rate_t     i_rate,
	input  logic      i_sda,
	output logic      o_ready,
	output logic      o_done,
	output logic      o_nack,
	output word_t     o_rd_data,
	output logic      o_scl_oe,
	output logic      o_sda_oe
);

	logic tick;
	logic busy;
	logic cmd_valid;
	byte_cmd_t cmd;
	logic byte_done;
	logic ack_ok;
	byte_t rx_byte;

	// rate frozen while the engine is busy
	i2c_rate_gen #(
		.P_RATE_DEFAULT(P_RATE_DEFAULT)
	) u_rate_gen (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_rate  (i_rate),
		.i_hold  (busy),
		.o_tick  (tick)
	);

	// byte sequence producer
	i2c_xfer_seq u_xfer_seq (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.i_req       (i_req),
		.i_byte_done (byte_done),
		.i_ack_ok    (ack_ok),
		.i_rx_byte   (rx_byte),
		.o_cmd_valid (cmd_valid),
		.o_cmd       (cmd),
		.o_ready     (o_ready),
		.o_done      (o_done),
		.o_nack      (o_nack),
		.o_rd_data   (o_rd_data)
	);

	// open drain pin driver
	i2c_bus_engine u_bus_engine (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_tick      (tick),
		.i_cmd_valid (cmd_valid),
		.i_cmd       (cmd),
		.i_sda       (i_sda),
		.o_busy      (busy),
		.o_byte_done (byte_done),
		.o_ack_ok    (ack_ok),
		.o_rx_byte   (rx_byte),
		.o_scl_oe    (o_scl_oe),
		.o_sda_oe    (o_sda_oe)
	);

endmodule

//--- source/i2c_eeprom_pkg.sv
package i2c_eeprom_pkg;

	// data bytes moved per transfer
	parameter int N_DATA_BYTES = 4;

	// bus field widths
	typedef logic [6:0] dev_addr_t;
	typedef logic [15:0] reg_addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [8*N_DATA_BYTES-1:0] word_t;
	typedef logic [2:0] rate_t;

	// scl period of 2^(rate+1) clocks, 6 is the fallback
	localparam rate_t RATE_DEFAULT = 3'd6;

	// one host request, 56 bits
	typedef struct packed {
		dev_addr_t dev_addr;
		reg_addr_t reg_addr;
		word_t     wr_data;
		logic      rd;
	} xfer_req_t;

	// one byte on the wire
	typedef struct packed {
		logic  start;
		logic  stop;
		logic  rx;
		byte_t tx_byte;
		logic  m_ack;
	} byte_cmd_t;

	// a receive right after START cannot happen on the bus,
	// so start together with rx codes a bare STOP
	localparam byte_cmd_t CMD_STOP_ONLY = '{start: 1'b1, stop: 1'b1, rx: 1'b1,
		tx_byte: 8'hff, m_ack: 1'b0};

	// engine phases
	typedef enum logic [2:0] {OP_IDLE, OP_START, OP_BIT, OP_ACK, OP_STOP} engine_op_t;

	// sequencer steps, named after the byte in flight
	typedef enum logic [2:0] {
		SEQ_IDLE, SEQ_ADDR_WR, SEQ_REG_HI, SEQ_REG_LO,
		SEQ_WR_DATA, SEQ_ADDR_RD, SEQ_RD_DATA, SEQ_DONE
	} seq_state_t;

endpackage

//--- source/i2c_rate_gen.sv
`timescale 1ns/10ps
module i2c_rate_gen import i2c_eeprom_pkg::*; #(
	parameter rate_t P_RATE_DEFAULT = RATE_DEFAULT
) (
	input  logic  i_clk,
	input  logic  i_rst_n,
	input  rate_t i_rate,
	input  logic  i_hold,
	output logic  o_tick
);

	rate_t rate_q;
	logic [5:0] div_cnt;
	logic [5:0] div_mask;

	// rate only moves between transfers
	// legal selects 4..7 all have the top bit set
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rate_q <= P_RATE_DEFAULT;
		end else if (!i_hold) begin
			rate_q <= i_rate[2] ? i_rate : P_RATE_DEFAULT;
		end
	end

	// tick every 2^(rate-1) clocks, four per scl period
	always_comb begin
		case (rate_q)
			3'd4: div_mask = 6'h07;
			3'd5: div_mask = 6'h0f;
			3'd6: div_mask = 6'h1f;
			default: div_mask = 6'h3f;
		endcase
	end

	// free running divider
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			div_cnt <= '0;
			o_tick <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 6'd1;
			o_tick <= ((div_cnt & div_mask) == div_mask);
		end
	end

endmodule

//--- source/i2c_xfer_seq.sv
`timescale 1ns/10ps
module i2c_xfer_seq import i2c_eeprom_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_start,
	input  xfer_req_t i_req,
	input  logic      i_byte_done,
	input  logic      i_ack_ok,
	input  byte_t     i_rx_byte,
	output logic      o_cmd_valid,
	output byte_cmd_t o_cmd,
	output logic      o_ready,
	output logic      o_done,
	output logic      o_nack,
	output word_t     o_rd_data
);

	localparam int CNT_W = $clog2(N_DATA_BYTES);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(N_DATA_BYTES - 1);

	seq_state_t state;
	xfer_req_t req_q;
	word_t rd_shift;
	logic [CNT_W-1:0] byte_cnt;
	logic [CNT_W-1:0] next_cnt;
	byte_t wr_byte;
	logic tx_phase;

	assign o_ready = (state == SEQ_IDLE);
	// index of the next data byte, zero for the first one
	assign next_cnt = (state == SEQ_WR_DATA || state == SEQ_RD_DATA) ? byte_cnt + 1'b1 : '0;
	// msb first, top byte lane goes out first
	assign wr_byte = req_q.wr_data[8*(N_DATA_BYTES-1-int'(next_cnt)) +: 8];
	// ack checked only where the master sent the byte
	assign tx_phase = (state == SEQ_ADDR_WR) || (state == SEQ_REG_HI) ||
		(state == SEQ_REG_LO) || (state == SEQ_WR_DATA) || (state == SEQ_ADDR_RD);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= SEQ_IDLE;
			byte_cnt <= '0;
			o_cmd_valid <= 1'b0;
			o_cmd <= '0;
			o_done <= 1'b0;
			o_nack <= 1'b0;
			o_rd_data <= '0;
		end else begin
			o_cmd_valid <= 1'b0;
			o_done <= 1'b0;
			if (state == SEQ_IDLE) begin
				if (i_start) begin
					state <= SEQ_ADDR_WR;
					o_cmd_valid <= 1'b1;
					o_cmd <= '{start: 1'b1, stop: 1'b0, rx: 1'b0,
						tx_byte: {i_req.dev_addr, 1'b0}, m_ack: 1'b0};
				end
			end else if (i_byte_done) begin
				if (state == SEQ_DONE) begin
					// bare stop after a nack is out
					state <= SEQ_IDLE;
					o_nack <= 1'b1;
					o_done <= 1'b1;
				end else if (tx_phase && !i_ack_ok) begin
					if (o_cmd.stop) begin
						// stop already went out with that byte
						state <= SEQ_IDLE;
						o_nack <= 1'b1;
						o_done <= 1'b1;
					end else begin
						state <= SEQ_DONE;
						o_cmd_valid <= 1'b1;
						o_cmd <= CMD_STOP_ONLY;
					end
				end else begin
					case (state)
						SEQ_ADDR_WR: begin
							state <= SEQ_REG_HI;
							o_cmd_valid <= 1'b1;
							o_cmd <= '{start: 1'b0, stop: 1'b0, rx: 1'b0,
								tx_byte: req_q.reg_addr[15:8], m_ack: 1'b0};
						end
						SEQ_REG_HI: begin
							state <= SEQ_REG_LO;
							o_cmd_valid <= 1'b1;
							// a read closes its address phase here
							o_cmd <= '{start: 1'b0, stop: req_q.rd, rx: 1'b0,
								tx_byte: req_q.reg_addr[7:0], m_ack: 1'b0};
						end
						SEQ_REG_LO: begin
							byte_cnt <= '0;
							o_cmd_valid <= 1'b1;
							if (req_q.rd) begin
								state <= SEQ_ADDR_RD;
								o_cmd <= '{start: 1'b1, stop: 1'b0, rx: 1'b0,
									tx_byte: {req_q.dev_addr, 1'b1}, m_ack: 1'b0};
							end else begin
								state <= SEQ_WR_DATA;
								o_cmd <= '{start: 1'b0, stop: (next_cnt == LAST_CNT), rx: 1'b0,
									tx_byte: wr_byte, m_ack: 1'b0};
							end
						end
						SEQ_WR_DATA: begin
							if (byte_cnt == LAST_CNT) begin
								state <= SEQ_IDLE;
								o_nack <= 1'b0;
								o_done <= 1'b1;
							end else begin
								byte_cnt <= next_cnt;
								o_cmd_valid <= 1'b1;
								o_cmd <= '{start: 1'b0, stop: (next_cnt == LAST_CNT), rx: 1'b0,
									tx_byte: wr_byte, m_ack: 1'b0};
							end
						end
						SEQ_ADDR_RD: begin
							state <= SEQ_RD_DATA;
							byte_cnt <= '0;
							o_cmd_valid <= 1'b1;
							o_cmd <= '{start: 1'b0, stop: (next_cnt == LAST_CNT), rx: 1'b1,
								tx_byte: 8'hff, m_ack: 1'b1};
						end
						SEQ_RD_DATA: begin
							if (byte_cnt == LAST_CNT) begin
								// only a clean read updates the output word
								state <= SEQ_IDLE;
								o_rd_data <= {rd_shift[$bits(word_t)-9:0], i_rx_byte};
								o_nack <= 1'b0;
								o_done <= 1'b1;
							end else begin
								byte_cnt <= next_cnt;
								o_cmd_valid <= 1'b1;
								// master acks every byte, last one too
								o_cmd <= '{start: 1'b0, stop: (next_cnt == LAST_CNT), rx: 1'b1,
									tx_byte: 8'hff, m_ack: 1'b1};
							end
						end
						default: state <= SEQ_IDLE;
					endcase
				end
			end
		end
	end

	// request and read assembly
	always_ff @(posedge i_clk) begin
		if (o_ready && i_start) begin
			req_q <= i_req;
		end
		if (i_byte_done && state == SEQ_RD_DATA) begin
			rd_shift <= {rd_shift[$bits(word_t)-9:0], i_rx_byte};
		end
	end

	// no command while idle
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_cmd_valid |-> !o_ready);

	// done and the return of ready always come together
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_done |-> o_ready);
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(o_ready) |-> o_done);

endmodule

//--- tb/eeprom_slave_model.sv
`timescale 1ns/10ps
module eeprom_slave_model import i2c_eeprom_pkg::*; #(
	parameter dev_addr_t P_DEV_ADDR = 7'h50
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_scl,
	input  logic i_sda,
	output logic o_sda_oe,
	output int   o_start_cnt
);

	typedef enum logic [2:0] {S_IDLE, S_DEV, S_REG_HI, S_REG_LO, S_WRITE, S_READ} slave_mode_t;

	slave_mode_t mode;
	byte_t mem [0:255];
	byte_t shreg;
	byte_t ptr;
	logic [3:0] bit_cnt;
	logic tx_arm;
	logic scl_q;
	logic sda_q;

	// known contents, every address holds a different byte
	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = 8'(i) ^ 8'ha5;
		end
	end

	// lines sampled on the system clock, edges found by comparing with last sample
	always @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mode <= S_IDLE;
			shreg <= '0;
			ptr <= '0;
			bit_cnt <= '0;
			tx_arm <= 1'b0;
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			o_sda_oe <= 1'b0;
			o_start_cnt <= 0;
		end else begin
			scl_q <= i_scl;
			sda_q <= i_sda;
			if (i_scl && scl_q && sda_q && !i_sda) begin
				// start, also a repeated one
				mode <= S_DEV;
				bit_cnt <= '0;
				tx_arm <= 1'b0;
				o_sda_oe <= 1'b0;
				o_start_cnt <= o_start_cnt + 1;
			end else if (i_scl && scl_q && !sda_q && i_sda) begin
				// stop
				mode <= S_IDLE;
				tx_arm <= 1'b0;
				o_sda_oe <= 1'b0;
			end else if (mode != S_IDLE) begin
				// first read bit waits until the master lets sda go,
				// a stop after the last byte keeps it low instead
				if (tx_arm && !i_scl && i_sda) begin
					o_sda_oe <= ~shreg[7];
					tx_arm <= 1'b0;
				end
				if (i_scl && !scl_q) begin
					if (bit_cnt == 4'd8) begin
						// master nack ends the read
						if (mode == S_READ && i_sda) begin
							mode <= S_IDLE;
						end
					end else if (mode == S_READ) begin
						shreg <= {shreg[6:0], 1'b0};
					end else begin
						shreg <= {shreg[6:0], i_sda};
					end
					bit_cnt <= bit_cnt + 4'd1;
				end
				if (!i_scl && scl_q) begin
					if (bit_cnt == 4'd8) begin
						// ack slot opens
						case (mode)
							S_DEV: begin
								if (shreg[7:1] == P_DEV_ADDR) begin
									o_sda_oe <= 1'b1;
									mode <= shreg[0] ? S_READ : S_REG_HI;
								end else begin
									mode <= S_IDLE;
								end
							end
							S_REG_HI: begin
								o_sda_oe <= 1'b1;
								mode <= S_REG_LO;
							end
							S_REG_LO: begin
								o_sda_oe <= 1'b1;
								ptr <= shreg;
								mode <= S_WRITE;
							end
							S_WRITE: begin
								o_sda_oe <= 1'b1;
								mem[ptr] <= shreg;
								ptr <= ptr + 8'd1;
							end
							// master acks the read byte
							default: o_sda_oe <= 1'b0;
						endcase
					end else if (bit_cnt == 4'd9) begin
						bit_cnt <= '0;
						o_sda_oe <= 1'b0;
						if (mode == S_READ) begin
							shreg <= mem[ptr];
							ptr <= ptr + 8'd1;
							tx_arm <= 1'b1;
						end
					end else if (mode == S_READ && bit_cnt != 4'd0) begin
						o_sda_oe <= ~shreg[7];
					end
				end
			end
		end
	end

endmodule

//--- tb/tb_i2c_eeprom_ctrl.sv
`timescale 1ns/10ps
module tb_i2c_eeprom_ctrl import i2c_eeprom_pkg::*; ();

	localparam dev_addr_t SLAVE_ADDR = 7'h50;
	localparam dev_addr_t ABSENT_ADDR = 7'h23;
	localparam int SCL_PER_XFER = 80;
	// five transfer slots at rate 4, two at rate 7, two at rate 6
	localparam int TIMEOUT_CYCLES = 2 * SCL_PER_XFER * (5 * 32 + 2 * 256 + 2 * 128);

	logic clk;
	logic rst_n;
	logic start;
	xfer_req_t req;
	rate_t rate;
	logic ready;
	logic done;
	logic nack;
	word_t rd_data;
	logic scl_oe;
	logic sda_oe;
	logic slave_sda_oe;
	logic scl;
	logic sda;
	int start_cnt;
	int cycles = 0;
	int done_cnt = 0;
	int last_pull = 0;
	int scl_period = 0;
	logic scl_oe_q = 1'b0;
	logic [31:0] rng_state = 32'hd61c_ee6a;
	reg_addr_t wr_addr;
	word_t wr_word;

	// open drain wiring with pull-ups
	assign scl = ~scl_oe;
	assign sda = ~(sda_oe | slave_sda_oe);

	i2c_eeprom_ctrl #(
		.P_RATE_DEFAULT(RATE_DEFAULT)
	) UUT (
		.i_clk     (clk),
		.i_rst_n   (rst_n),
		.i_start   (start),
		.i_req     (req),
		.i_rate    (rate),
		.i_sda     (sda),
		.o_ready   (ready),
		.o_done    (done),
		.o_nack    (nack),
		.o_rd_data (rd_data),
		.o_scl_oe  (scl_oe),
		.o_sda_oe  (sda_oe)
	);

	eeprom_slave_model #(
		.P_DEV_ADDR(SLAVE_ADDR)
	) eeprom (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.i_scl       (scl),
		.i_sda       (sda),
		.o_sda_oe    (slave_sda_oe),
		.o_start_cnt (start_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run;
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// run length guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("TIMEOUT after %0d cycles, the tests did not finish", cycles);
			abort_run();
		end
	end

	// done pulses and the spacing of scl pulls, sampled mid cycle
	always @(negedge clk) begin
		scl_oe_q <= scl_oe;
		if (done) begin
			done_cnt <= done_cnt + 1;
		end
		if (scl_oe && !scl_oe_q) begin
			scl_period <= cycles - last_pull;
			last_pull <= cycles;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// scl period in clocks, selects below 4 fall back to 6
	function automatic int scl_clocks(input rate_t sel);
		int eff;
		eff = (sel >= 3'd4) ? int'(sel) : 6;
		return 1 << (eff + 1);
	endfunction

	function automatic xfer_req_t make_req(input dev_addr_t dev, input reg_addr_t addr,
		input word_t data, input logic rd);
		xfer_req_t r;
		r.dev_addr = dev;
		r.reg_addr = addr;
		r.wr_data = data;
		r.rd = rd;
		return r;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic wait_done;
		@(negedge clk);
		while (!done) begin
			@(negedge clk);
		end
	endtask

	// one start pulse, then wait for the end of the transfer
	task automatic run_xfer(input xfer_req_t r);
		@(posedge clk);
		#1;
		req = r;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		wait_done();
	endtask

	task automatic write_and_check(input reg_addr_t addr, input word_t data, input int period);
		run_xfer(make_req(SLAVE_ADDR, addr, data, 1'b0));
		check_bit("o_nack", nack, 1'b0);
		check_count("scl period", scl_period, period);
		// first byte on the wire lands at the lowest address
		for (int k = 0; k < N_DATA_BYTES; k++) begin
			check_byte("eeprom.mem", eeprom.mem[8'(addr[7:0] + k)],
				data[8 * (N_DATA_BYTES - 1 - k) +: 8]);
		end
	endtask

	task automatic read_and_check(input reg_addr_t addr, input word_t exp, input int period);
		int starts;
		starts = start_cnt;
		run_xfer(make_req(SLAVE_ADDR, addr, '0, 1'b1));
		check_bit("o_nack", nack, 1'b0);
		check_word("o_rd_data", rd_data, exp);
		check_count("scl period", scl_period, period);
		// address phase and read phase each open with a start
		check_count("start conditions", start_cnt - starts, 2);
	endtask

	task automatic reset_defaults;
		@(negedge clk);
		check_bit("o_ready", ready, 1'b1);
		check_bit("o_done", done, 1'b0);
		check_bit("o_nack", nack, 1'b0);
		check_bit("o_scl_oe", scl_oe, 1'b0);
		check_bit("o_sda_oe", sda_oe, 1'b0);
		check_word("o_rd_data", rd_data, '0);
	endtask

	task automatic write_random_word;
		rng_state = xorshift32(rng_state);
		wr_addr = rng_state[15:0];
		rng_state = xorshift32(rng_state);
		wr_word = rng_state;
		write_and_check(wr_addr, wr_word, scl_clocks(rate));
	endtask

	task automatic read_back_word;
		read_and_check(wr_addr, wr_word, scl_clocks(rate));
	endtask

	// nobody answers, last read word must survive
	task automatic absent_device;
		run_xfer(make_req(ABSENT_ADDR, wr_addr, '0, 1'b1));
		check_bit("o_nack", nack, 1'b1);
		check_word("o_rd_data", rd_data, wr_word);
		check_bit("o_ready", ready, 1'b1);
	endtask

	task automatic rate_sweep;
		rate_t sel;
		for (int i = 0; i < 2; i++) begin
			// slowest legal rate, then an illegal one
			sel = (i == 0) ? 3'd7 : 3'd2;
			@(posedge clk);
			#1;
			rate = sel;
			rng_state = xorshift32(rng_state);
			wr_addr = rng_state[31:16];
			rng_state = xorshift32(rng_state);
			wr_word = rng_state;
			write_and_check(wr_addr, wr_word, scl_clocks(sel));
			read_and_check(wr_addr, wr_word, scl_clocks(sel));
		end
		@(posedge clk);
		#1;
		rate = 3'd4;
	endtask

	task automatic ignore_busy_start;
		int dones;
		dones = done_cnt;
		rng_state = xorshift32(rng_state);
		wr_word = rng_state;
		@(posedge clk);
		#1;
		req = make_req(SLAVE_ADDR, wr_addr, wr_word, 1'b0);
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		repeat (50) @(posedge clk);
		#1;
		check_bit("o_ready", ready, 1'b0);
		// read request in the middle of the write
		req = make_req(SLAVE_ADDR, wr_addr, '0, 1'b1);
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		wait_done();
		check_bit("o_nack", nack, 1'b0);
		// room for a second transfer that must not come
		repeat (SCL_PER_XFER * scl_clocks(rate)) @(negedge clk);
		check_count("o_done pulses", done_cnt - dones, 1);
		check_bit("o_ready", ready, 1'b1);
		check_byte("eeprom.mem", eeprom.mem[wr_addr[7:0]], wr_word[31:24]);
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		req = '0;
		rate = 3'd4;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_defaults();
		write_random_word();
		read_back_word();
		absent_device();
		rate_sweep();
		ignore_busy_start();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
